// ==== cen_gate.sv ====
// ============================
// wait controller for the 6809 strobes
//   blocks the clock enables while a shared
//   device is busy or a ROM fetch is pending
// ============================
`timescale 1ns/10ps

module cen_gate (
    input  logic clk,
    input  logic rstn,
    input  logic dev_busy,
    input  logic rom_cs,
    input  logic rom_ok,
    output logic gate
);
    import m6809_pkg::*;

    wait_t st;
    wait_t st_nx;
    logic  rom_bad;

    // fetch requested but the data is not there yet
    assign rom_bad = rom_cs & ~rom_ok;

    // rom_ok must hold for two clks before release,
    // a stale rom_ok right after an address change gets absorbed here
    always_comb begin
        st_nx = st;
        case (st)
            WT_RUN:    if (rom_bad) st_nx = WT_ROM;
            WT_ROM:    if (rom_ok) st_nx = WT_SETTLE;
            WT_SETTLE: st_nx = rom_ok ? WT_RUN : WT_ROM;   // ok dropped, wait again
            default:   st_nx = WT_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            st <= WT_RUN;
        end else begin
            st <= st_nx;
        end
    end

    // rom_bad also closes the gate on the very clk the fetch starts
    always_comb begin
        gate = ~dev_busy & ~rom_bad & (st == WT_RUN);
    end

endmodule

// ==== cpu_bus_ctrl.sv ====
// ============================
// 6809 bus side glue
//   VMA register, interrupt ack decode,
//   RAM write enable, Konami-1 decryption
// ============================
`timescale 1ns/10ps

module cpu_bus_ctrl (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cen_E,
    input  logic        avma,
    input  logic        rnw,
    input  logic        ram_cs,
    input  logic        op,         // opcode fetch cycle
    input  logic        ba,
    input  logic        bs,
    input  logic        konami_en,  // board uses the Konami-1 CPU
    input  logic [15:0] addr,
    input  logic [7:0]  cpu_din,
    output logic        vma,
    output logic        irq_ack,
    output logic        ram_we,
    output logic [7:0]  din_dec
);

    logic [7:0] key;
    logic       decode;

    // AVMA announces the next cycle, so it is latched on E
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vma <= 1'b1;
        end else if (cen_E) begin
            vma <= avma;
        end
    end

    assign irq_ack = ~ba & bs;     // BA/BS = 01 is vector fetch
    assign ram_we  = ram_cs & ~rnw;

    // Konami-1 only scrambles opcode bytes, odd bits from A1 and A3
    assign key    = {addr[1], 1'b0, ~addr[1], 1'b0, addr[3], 1'b0, ~addr[3], 1'b0};
    assign decode = konami_en & op;

    always_comb begin
        if (decode) begin
            din_dec = cpu_din ^ key;
        end else begin
            din_dec = cpu_din;
        end
    end

endmodule

// ==== cpu_cen_gen.sv ====
// ============================
// 6809 E/Q phase strobe generator
//   divides cen by four into cen_E/cen_Q,
//   pauses on waits, recovers missed slots
// ============================
`timescale 1ns/10ps

module cpu_cen_gen (
    input  logic clk,
    input  logic rstn,
    input  logic cen,       // CPU input clock enable, one clk wide
    input  logic dev_busy,
    input  logic rom_cs,
    input  logic rom_ok,
    output logic cen_E,
    output logic cen_Q
);
    import m6809_pkg::*;

    phase_t     phase;
    logic       gate;
    logic       last_half;  // phase[1] at the last gated cen
    logic       last_eq;    // strobe on the previous cen
    logic       eq;
    logic       catchup;
    logic [3:0] misses;

    cen_gate u_gate (
        .clk      ( clk      ),
        .rstn     ( rstn     ),
        .dev_busy ( dev_busy ),
        .rom_cs   ( rom_cs   ),
        .rom_ok   ( rom_ok   ),
        .gate     ( gate     )
    );

    assign eq      = cen_E | cen_Q;
    assign catchup = RECOVERY_EN && (misses != 4'd0);

    always_comb begin
        cen_E = cen && gate && (phase == PH_E);
        cen_Q = cen && gate && (phase == PH_Q);
    end

    // While gated off, the phase may still step through the gap
    // of the current half cycle. It then parks on the pending
    // strobe phase and each blocked cen there counts as a miss.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase     <= PH_E;
            last_half <= 1'b1;  // so PH_E parks instead of sliding to Q
            last_eq   <= 1'b0;
            misses    <= 4'd0;
        end else if (cen) begin
            last_eq <= eq;
            if (gate) begin
                last_half <= phase[1];
            end
            if (gate && catchup) begin
                // skip the gap, strobes on consecutive cen pulses
                phase  <= phase_t'({~phase[1], 1'b0});
                misses <= misses - 4'd1;
            end else if (gate || phase[1] == last_half) begin
                phase <= phase_t'(phase + 2'd1);
            end else if (!last_eq && misses != MISS_MAX) begin
                misses <= misses + 4'd1;    // lost slot
            end
        end
    end

endmodule

// ==== cpu_ram.sv ====
// ============================
// single-port CPU work RAM
//   written and read on cen_Q
// ============================
`timescale 1ns/10ps

module cpu_ram (
    input  logic                        clk,
    input  logic                        cen,
    input  logic [m6809_pkg::RAM_AW-1:0] addr,
    input  logic [7:0]                  data,
    input  logic                        we,
    output logic [7:0]                  q
);
    import m6809_pkg::*;

    logic [7:0] mem [0:(2**RAM_AW)-1];

    // read-before-write, q holds the old word on a write
    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= data;
            end
            q <= mem[addr];
        end
    end

endmodule

// ==== m6809_pkg.sv ====
// ============================
// shared constants and enums for the
// 6809 clock and bus adapter
//   work RAM size, recovery control,
//   phase and wait-state encodings
// ============================

package m6809_pkg;

    // work RAM address width, 1 kB
    localparam int RAM_AW = 10;

    // missed-slot recovery on/off
    localparam bit RECOVERY_EN = 1'b1;

    localparam logic [3:0] MISS_MAX = 4'd15;   // miss counter saturates here

    // position inside one E/Q bus cycle
    // cen_E fires at PH_E, cen_Q fires at PH_Q
    typedef enum logic [1:0] {
        PH_E  = 2'b00,
        PH_EQ = 2'b01,  // gap between E and Q
        PH_Q  = 2'b10,
        PH_QE = 2'b11   // gap before next E
    } phase_t;

    // wait controller states
    typedef enum logic [1:0] {
        WT_RUN    = 2'd0,  // free running
        WT_ROM    = 2'd1,  // SDRAM fetch pending
        WT_SETTLE = 2'd2   // first clk of rom_ok seen
    } wait_t;

endpackage

// ==== project.f ====
m6809_pkg.sv
cen_gate.sv
cpu_cen_gen.sv
cpu_ram.sv
cpu_bus_ctrl.sv
sys6809_top.sv
sys6809_assert.sv
sys6809_checker.sv
tb_sys6809.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the testbench with Verilator, run it and scan the log
rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_sys6809 \
        -f project.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    && grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sys6809_assert.sv ====
// ==============================
// concurrent checks on the E/Q strobe
// generator, bound into cpu_cen_gen
// ==============================
`timescale 1ns/10ps

module sys6809_assert (
    input logic              clk,
    input logic              rstn,
    input logic              cen,
    input logic              gate,
    input m6809_pkg::phase_t phase,
    input logic              cen_E,
    input logic              cen_Q
);
    import m6809_pkg::*;

    int fails = 0;  // read by the testbench at the end

    strobe_needs_cen: assert property (@(posedge clk) disable iff (!rstn)
        (cen_E || cen_Q) |-> cen)
        else begin
            $error("strobe without cen");
            fails++;
        end

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(cen_E && cen_Q))
        else begin
            $error("cen_E and cen_Q high together");
            fails++;
        end

    strobe_needs_gate: assert property (@(posedge clk) disable iff (!rstn)
        (cen_E || cen_Q) |-> gate)
        else begin
            $error("strobe while the gate is closed");
            fails++;
        end

    // phase parked on E during reset
    reset_phase: assert property (@(posedge clk) !rstn |-> phase == PH_E)
        else begin
            $error("phase left PH_E in reset");
            fails++;
        end

endmodule

bind cpu_cen_gen sys6809_assert u_assert (
    .clk   ( clk   ),
    .rstn  ( rstn  ),
    .cen   ( cen   ),
    .gate  ( gate  ),
    .phase ( phase ),
    .cen_E ( cen_E ),
    .cen_Q ( cen_Q )
);

// ==== sys6809_checker.sv ====
// ==============================
// monitor for the 6809 adapter
//   strobe and wait model, reference RAM,
//   VMA, interrupt ack, Konami-1 checks
// ==============================
`timescale 1ns/10ps

module sys6809_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cen,
    input  logic        dev_busy,
    input  logic        rom_cs, rom_ok,
    input  logic        ram_cs, konami_en,
    input  logic [15:0] addr,
    input  logic        rnw, avma, op, ba, bs,
    input  logic [7:0]  cpu_dout, cpu_din,
    input  logic        cen_E, cen_Q, cpu_cen,
    input  logic        vma, irq_ack,
    input  logic [7:0]  ram_dout, din_dec,
    output int          errors
);
    import m6809_pkg::*;

    logic [7:0] ref_mem [0:(2**RAM_AW)-1];
    logic       ref_ok  [0:(2**RAM_AW)-1];   // address written at least once
    logic       rom_pend;                    // fetch wait active
    int         ok_run;                      // consecutive clks of rom_ok
    logic       want_e;                      // kind of the next strobe slot
    logic       in_gap;
    logic       prev_strobe;
    int         miss;
    logic       last_e;
    logic       exp_vma;
    logic       rd_chk;
    logic [7:0] rd_exp;
    int         err_cnt = 0;

    assign errors = err_cnt;

    initial begin
        exp_vma = 1'b1;
        rd_chk  = 1'b0;
        for (int i = 0; i < 2**RAM_AW; i++) begin
            ref_ok[i] = 1'b0;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // odd bits from A1 and A3 and their inverses with even bits clear
    function automatic logic [7:0] konami_key(input logic [15:0] a);
        logic [7:0] k;
        k    = 8'h00;
        k[7] = a[1];
        k[5] = ~a[1];
        k[3] = a[3];
        k[1] = ~a[3];
        return k;
    endfunction

    always @(negedge clk) begin : monitor
        logic              g;
        logic              e_exp;
        logic              q_exp;
        logic [RAM_AW-1:0] a;
        a = addr[RAM_AW-1:0];
        if (rd_chk) begin   // read launched on the last cen_Q
            check_byte("ram_dout", ram_dout, rd_exp);
            rd_chk = 1'b0;
        end
        check_bit("vma", vma, exp_vma);
        check_bit("irq_ack", irq_ack, !ba && bs);
        check_byte("din_dec", din_dec, (konami_en && op) ? cpu_din ^ konami_key(addr) : cpu_din);
        if (!rstn) begin
            rom_pend    = 1'b0;
            ok_run      = 0;
            want_e      = 1'b1;
            in_gap      = 1'b0;
            prev_strobe = 1'b0;
            miss        = 0;
            last_e      = 1'b0;
            exp_vma     = 1'b1;
        end else begin
            g     = !dev_busy && !(rom_cs && !rom_ok) && !rom_pend;
            e_exp = cen && g && !in_gap && want_e;
            q_exp = cen && g && !in_gap && !want_e;
            check_bit("cen_E", cen_E, e_exp);
            check_bit("cen_Q", cen_Q, q_exp);
            check_bit("cpu_cen", cpu_cen, q_exp);
            if ((cen_E || cen_Q) && !g) begin
                err_cnt++;
                $display("strobe at %0t although a wait was active", $time);
            end
            if ((cen_E && last_e) || (cen_Q && !last_e)) begin
                err_cnt++;
                $display("strobes out of order at %0t, E and Q did not alternate", $time);
            end
            if (cen_E || cen_Q) begin
                last_e = cen_E;
            end
            if (cen) begin
                if (in_gap) begin
                    in_gap = 1'b0;          // gap slot needs no gate
                end else if (g) begin
                    want_e = ~want_e;
                    if (RECOVERY_EN && miss > 0) begin
                        miss--;             // catching up skips the gap
                    end else begin
                        in_gap = 1'b1;
                    end
                end else if (!prev_strobe && miss < MISS_MAX) begin
                    miss++;
                end
                prev_strobe = e_exp || q_exp;
            end
            // ROM release after two clks of rom_ok
            if (rom_pend) begin
                ok_run = rom_ok ? ok_run + 1 : 0;
                if (ok_run == 2) begin
                    rom_pend = 1'b0;
                    ok_run   = 0;
                end
            end else if (rom_cs && !rom_ok) begin
                rom_pend = 1'b1;
                ok_run   = 0;
            end
            if (cen_E) begin
                exp_vma = avma;
            end
            if (cen_Q) begin
                if (ram_cs && rnw && ref_ok[a]) begin
                    rd_chk = 1'b1;
                    rd_exp = ref_mem[a];
                end
                if (ram_cs && !rnw) begin
                    ref_mem[a] = cpu_dout;
                    ref_ok[a]  = 1'b1;
                end
            end
        end
    end

endmodule

// ==== sys6809_top.sv ====
// ============================
// 6809 bus and clock adapter top level
//   phase generator, bus glue, work RAM
// ============================
`timescale 1ns/10ps

module sys6809_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cen,
    // memory system side
    input  logic        dev_busy,
    input  logic        rom_cs,
    input  logic        rom_ok,
    input  logic        ram_cs,
    input  logic        konami_en,
    // from the CPU core
    input  logic [15:0] addr,
    input  logic        rnw,
    input  logic [7:0]  cpu_dout,
    input  logic        avma,
    input  logic        op,
    input  logic        ba,
    input  logic        bs,
    input  logic [7:0]  cpu_din,    // external bus mux output
    // strobes
    output logic        cen_E,
    output logic        cen_Q,
    output logic        cpu_cen,
    // bus status and data
    output logic        vma,
    output logic        irq_ack,
    output logic [7:0]  ram_dout,
    output logic [7:0]  din_dec
);
    import m6809_pkg::*;

    logic ram_we;

    assign cpu_cen = cen_Q;

    cpu_cen_gen u_cen (
        .clk      ( clk      ),
        .rstn     ( rstn     ),
        .cen      ( cen      ),
        .dev_busy ( dev_busy ),
        .rom_cs   ( rom_cs   ),
        .rom_ok   ( rom_ok   ),
        .cen_E    ( cen_E    ),
        .cen_Q    ( cen_Q    )
    );

    cpu_bus_ctrl u_bus (
        .clk       ( clk       ),
        .rstn      ( rstn      ),
        .cen_E     ( cen_E     ),
        .avma      ( avma      ),
        .rnw       ( rnw       ),
        .ram_cs    ( ram_cs    ),
        .op        ( op        ),
        .ba        ( ba        ),
        .bs        ( bs        ),
        .konami_en ( konami_en ),
        .addr      ( addr      ),
        .cpu_din   ( cpu_din   ),
        .vma       ( vma       ),
        .irq_ack   ( irq_ack   ),
        .ram_we    ( ram_we    ),
        .din_dec   ( din_dec   )
    );

    // RAM runs on Q, data from the core is valid by then
    cpu_ram u_ram (
        .clk  ( clk                ),
        .cen  ( cen_Q              ),
        .addr ( addr[RAM_AW-1:0]   ),
        .data ( cpu_dout           ),
        .we   ( ram_we             ),
        .q    ( ram_dout           )
    );

endmodule

// ==== tb_sys6809.sv ====
// ==============================
// testbench top for the 6809 adapter
//   clock, reset, random bus and memory
//   stimulus, DUT and monitor
// ==============================
`timescale 1ns/10ps

module tb_sys6809;

    localparam int STROBE_TARGET = 400;     // cen_Q strobes per run
    localparam int FIRST_E_LIMIT = 256;     // clks
    localparam int RUN_LIMIT     = 40000;   // clks

    logic        clk = 1'b0;
    logic        rstn;
    logic        cen, dev_busy, rom_cs, rom_ok, ram_cs, konami_en;
    logic [15:0] addr;
    logic        rnw, avma, op, ba, bs;
    logic [7:0]  cpu_dout, cpu_din;
    logic        cen_E, cen_Q, cpu_cen, vma, irq_ack;
    logic [7:0]  ram_dout, din_dec;

    integer seed;
    int     busy_left;
    int     rom_left;
    int     n_q;
    int     cnt;
    int     chk_errors;
    int     asrt_errors;
    logic   e_seen;
    logic   timed_out;

    sys6809_top dut (.*);

    sys6809_checker u_chk (
        .errors ( chk_errors ),
        .*
    );

    always #5 clk = ~clk;

    // one clk of stimulus where the CPU bus only moves after a cen_E
    task automatic step_bus();
        logic [31:0] r;
        @(negedge clk);
        e_seen = cen_E;
        if (cen_Q) begin
            n_q++;
        end
        @(posedge clk);
        #1;
        r   = $random(seed);
        cen = ~cen;
        if (busy_left > 0) begin
            busy_left--;
        end else if (r[6:0] == 7'd0) begin
            busy_left = 2 + int'(r[31:26]);     // busy burst
        end
        dev_busy = (busy_left > 0);
        if (!rom_cs && r[11:7] == 5'd0) begin
            rom_cs   = 1'b1;                    // new SDRAM fetch
            rom_ok   = 1'b0;
            rom_left = int'(r[15:12]);
        end else if (rom_cs) begin
            if (rom_left > 0) begin
                rom_left--;
            end else if (!rom_ok) begin
                rom_ok   = 1'b1;
                rom_left = 1 + int'(r[17:16]);
            end else begin
                rom_cs = 1'b0;
                rom_ok = 1'b0;
            end
        end
        if (e_seen) begin
            r        = $random(seed);
            addr     = {r[15:10], 5'd0, r[4:0]};  // small window so RAM words repeat
            rnw      = r[16];
            ram_cs   = r[17];
            avma     = r[18];
            op       = r[19];
            ba       = r[20];
            bs       = r[21];
            cpu_dout = r[31:24];
            r        = $random(seed);
            cpu_din  = r[7:0];
        end
    endtask

    initial begin
        rstn      = 1'b1;
        cen       = 1'b0;
        dev_busy  = 1'b0;
        rom_cs    = 1'b0;
        rom_ok    = 1'b0;
        ram_cs    = 1'b0;
        konami_en = 1'b1;   // board variant with the Konami-1 CPU
        addr      = 16'h0000;
        rnw       = 1'b1;
        avma      = 1'b0;
        op        = 1'b0;
        ba        = 1'b0;
        bs        = 1'b0;
        cpu_dout  = 8'h00;
        cpu_din   = 8'h00;
        seed      = 32'haabde28e;
        busy_left = 0;
        rom_left  = 0;
        n_q       = 0;
        e_seen    = 1'b0;
        timed_out = 1'b0;
        #1;
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        cnt = 0;
        while (!e_seen && cnt < FIRST_E_LIMIT) begin
            step_bus();
            cnt++;
        end
        if (!e_seen) begin
            $display("timeout: no cen_E seen after reset");
            timed_out = 1'b1;
        end
        cnt = 0;
        while (!timed_out && n_q < STROBE_TARGET && cnt < RUN_LIMIT) begin
            step_bus();
            cnt++;
            if (n_q == STROBE_TARGET / 2) begin
                konami_en = 1'b0;   // second half as the plain 6809 board
            end
        end
        if (!timed_out && n_q < STROBE_TARGET) begin
            $display("timeout: only %0d cen_Q strobes in %0d clks", n_q, RUN_LIMIT);
            timed_out = 1'b1;
        end
        asrt_errors = dut.u_cen.u_assert.fails;
        $display("cen_Q strobes %0d, monitor errors %0d, assertion errors %0d, timeouts %0d",
                 n_q, chk_errors, asrt_errors, timed_out);
        if (chk_errors == 0 && asrt_errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
